/* Makefile */
# Verilator build for the status overlay

VERILATOR ?= verilator
TOP       ?= tb_overlay
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the run prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* project.f */
source/overlay_pkg.sv
source/video_timing.sv
source/char_rom.sv
source/ui_overlay.sv
source/video_mixer.sv
source/overlay_top.sv
tests/tb_overlay.sv

/* source/char_rom.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8x8 font ROM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module char_rom (
  input  logic       clk,
  input  logic [6:0] code,  // ascii minus 32
  input  logic [2:0] row,
  output logic [7:0] font_line
);

  localparam int LAST_CODE = 90;  // lower case z

  // one glyph per entry, top row in the high byte, bit 7 is leftmost
  localparam logic [63:0] FONT [LAST_CODE+1] = '{
    64'h0000000000000000, 64'h183C3C1818001800, 64'h6C6C000000000000,  // sp ! "
    64'h6C6CFE6CFE6C6C00, 64'h307CC0780CF83000, 64'h00C6CC183066C600,  // # $ %
    64'h386C3876DCCC7600, 64'h6060C00000000000, 64'h1830606060301800,  // & ' (
    64'h6030181818306000, 64'h00663CFF3C660000, 64'h003030FC30300000,  // ) * +
    64'h0000000000303060, 64'h000000FC00000000, 64'h0000000000303000,  // , - .
    64'h060C183060C08000, 64'h7CC6CEDEF6E67C00, 64'h30703030303030FC,  // / 0 1
    64'h78CC0C3860CCFC00, 64'h78CC0C380CCC7800, 64'h1C3C6CCCFE0C1E00,  // 2 3 4
    64'hFCC0F80C0CCC7800, 64'h3860C0F8CCCC7800, 64'hFCCC0C1830303000,  // 5 6 7
    64'h78CCCC78CCCC7800, 64'h78CCCC7C0C187000, 64'h0030300000303000,  // 8 9 :
    64'h0030300000303060, 64'h183060C060301800, 64'h0000FC0000FC0000,  // ; < =
    64'h6030180C18306000, 64'h78CC0C1830003000, 64'h7CC6DEDEDEC07800,  // > ? @
    64'h3078CCCCFCCCCC00, 64'hFC66667C6666FC00, 64'h3C66C0C0C0663C00,  // A B C
    64'hF86C6666666CF800, 64'hFE6268786862FE00, 64'hFE6268786860F000,  // D E F
    64'h3C66C0C0CE663E00, 64'hCCCCCCFCCCCCCC00, 64'h7830303030307800,  // G H I
    64'h1E0C0C0CCCCC7800, 64'hE6666C786C66E600, 64'hF06060606266FE00,  // J K L
    64'hC6EEFEFED6C6C600, 64'hC6E6F6DECEC6C600, 64'h386CC6C6C66C3800,  // M N O
    64'hFC66667C6060F000, 64'h78CCCCCCDC781C00, 64'hFC66667C6C66E600,  // P Q R
    64'h78CCE0701CCC7800, 64'hFCB4303030307800, 64'hCCCCCCCCCCCCFC00,  // S T U
    64'hCCCCCCCCCC783000, 64'hC6C6C6D6FEEEC600, 64'hC6C66C38386CC600,  // V W X
    64'hCCCCCC7830307800, 64'hFEC68C183266FE00, 64'h7860606060607800,  // Y Z [
    64'hC06030180C060200, 64'h7818181818187800, 64'h10386CC600000000,  // \ ] ^
    64'h00000000000000FF, 64'h3030180000000000, 64'h0000780C7CCC7600,  // _ ` a
    64'hE060607C6666DC00, 64'h000078CCC0CC7800, 64'h1C0C0C7CCCCC7600,  // b c d
    64'h000078CCFCC07800, 64'h386C60F06060F000, 64'h000076CCCC7C0CF8,  // e f g
    64'hE0606C766666E600, 64'h3000703030307800, 64'h0C000C0C0CCCCC78,  // h i j
    64'hE060666C786CE600, 64'h7030303030307800, 64'h0000CCFEFED6C600,  // k l m
    64'h0000F8CCCCCCCC00, 64'h000078CCCCCC7800, 64'h0000DC66667C60F0,  // n o p
    64'h000076CCCC7C0C1E, 64'h0000DC766660F000, 64'h00007CC0780CF800,  // q r s
    64'h10307C3030341800, 64'h0000CCCCCCCC7600, 64'h0000CCCCCC783000,  // t u v
    64'h0000C6D6FEFE6C00, 64'h0000C66C386CC600, 64'h0000CCCCCC7C0CF8,  // w x y
    64'h0000FC983064FC00                                               // z
  };

  logic [63:0] glyph;

  always_comb begin
    glyph = '0;  // codes past z are blank
    if (code <= 7'(LAST_CODE)) glyph = FONT[code];
  end

  // registered read like a block RAM
  always_ff @(posedge clk) begin
    font_line <= glyph[8*(7-int'(row)) +: 8];
  end

endmodule

/* source/overlay_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Status overlay shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package overlay_pkg;

  typedef enum logic [2:0] {
    SPEED_1X  = 3'd0,
    SPEED_2X  = 3'd1,
    SPEED_4X  = 3'd2,
    SPEED_50X = 3'd3,
    SPEED_MAX = 3'd4  // codes 5 to 7 behave like this one
  } speed_e;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic       de;
    logic       hsync;
    logic       vsync;
  } fetch_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    rgb_t rgb;
    logic de;
    logic hsync;
    logic vsync;
  } video_t;

  localparam int MAIN_TEXT_LENGTH  = 13;
  localparam int SPEED_TEXT_LENGTH = 3;
  localparam int GLYPH_SIZE        = 8;  // font cell edge in pixels

  // first character sits in the top byte
  localparam logic [8*MAIN_TEXT_LENGTH-1:0] MAIN_TEXT = "Turbo Speed: ";

endpackage

/* source/overlay_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Status overlay top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module overlay_top #(
  parameter int H_ACTIVE       = 360,
  parameter int H_TOTAL        = 400,
  parameter int V_ACTIVE       = 320,
  parameter int V_TOTAL        = 330,
  parameter int UI_SCALE       = 2,
  parameter int BAND_START_Y   = 276,
  parameter int TEXT_PADDING_Y = 10
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [2:0]          turbo_speed,
  input  overlay_pkg::rgb_t   background,  // pixel for the current fetch
  output overlay_pkg::video_t video_out    // two clocks behind fetch
);

  overlay_pkg::fetch_t fetch;
  logic                overlay_pixel;
  logic                in_band;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_ACTIVE (V_ACTIVE),
    .V_TOTAL  (V_TOTAL)
  ) u_video_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .fetch (fetch)
  );

  ui_overlay #(
    .H_ACTIVE       (H_ACTIVE),
    .H_TOTAL        (H_TOTAL),
    .V_ACTIVE       (V_ACTIVE),
    .UI_SCALE       (UI_SCALE),
    .BAND_START_Y   (BAND_START_Y),
    .TEXT_PADDING_Y (TEXT_PADDING_Y)
  ) u_ui_overlay (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch         (fetch),
    .turbo_speed   (turbo_speed),
    .overlay_pixel (overlay_pixel),
    .in_band       (in_band)
  );

  video_mixer u_video_mixer (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch         (fetch),
    .background    (background),
    .overlay_pixel (overlay_pixel),
    .in_band       (in_band),
    .video_out     (video_out)
  );

endmodule

/* source/ui_overlay.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Turbo speed text overlay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ui_overlay #(
  parameter int H_ACTIVE       = 360,
  parameter int H_TOTAL        = 400,
  parameter int V_ACTIVE       = 320,
  parameter int UI_SCALE       = 2,
  parameter int BAND_START_Y   = 276,
  parameter int TEXT_PADDING_Y = 10
) (
  input  logic                clk,
  input  logic                rst_n,
  input  overlay_pkg::fetch_t fetch,
  input  logic [2:0]          turbo_speed,
  output logic                overlay_pixel,  // white when set
  output logic                in_band
);

  localparam int MAIN_LEN     = overlay_pkg::MAIN_TEXT_LENGTH;
  localparam int TEXT_CHARS   = MAIN_LEN + overlay_pkg::SPEED_TEXT_LENGTH;
  localparam int CELL_W       = overlay_pkg::GLYPH_SIZE * UI_SCALE;  // scaled cell edge
  localparam int TEXT_WIDTH   = TEXT_CHARS * CELL_W;
  localparam int TEXT_START_X = (H_ACTIVE - TEXT_WIDTH) / 2;  // centred
  localparam int TEXT_END_X   = TEXT_START_X + TEXT_WIDTH;
  localparam int TEXT_START_Y = BAND_START_Y + TEXT_PADDING_Y;
  localparam int TEXT_END_Y   = TEXT_START_Y + CELL_W;
  localparam int BAND_END_Y   = TEXT_END_Y + TEXT_PADDING_Y;

  function automatic logic [8*overlay_pkg::SPEED_TEXT_LENGTH-1:0] speed_text(
    overlay_pkg::speed_e speed
  );
    case (speed)
      overlay_pkg::SPEED_1X:  speed_text = " 1x";
      overlay_pkg::SPEED_2X:  speed_text = " 2x";
      overlay_pkg::SPEED_4X:  speed_text = " 4x";
      overlay_pkg::SPEED_50X: speed_text = "50x";
      default:                speed_text = "Max";
    endcase
  endfunction

  logic [9:0]  next_x;
  logic [9:0]  next_off;
  logic [9:0]  char_idx;
  logic [23:0] suffix;
  logic [7:0]  ascii;
  logic [6:0]  char_code_q;
  logic [9:0]  x_off;
  logic [9:0]  y_off;
  logic [2:0]  glyph_row;
  logic [2:0]  glyph_col;
  logic        text_hit;
  logic        band_hit;
  logic [2:0]  col_q;
  logic        text_q;
  logic        band_q;
  logic [7:0]  font_line;

  // character lookup runs one pixel ahead of the fetch
  assign next_x   = (fetch.x == 10'(H_TOTAL - 1)) ? '0 : fetch.x + 10'd1;
  assign next_off = next_x - 10'(TEXT_START_X);
  assign char_idx = 10'(next_off / CELL_W);
  assign suffix   = speed_text(overlay_pkg::speed_e'(turbo_speed));

  always_comb begin
    ascii = " ";
    if (char_idx < 10'(MAIN_LEN)) begin
      ascii = overlay_pkg::MAIN_TEXT[8*(MAIN_LEN-1-int'(char_idx)) +: 8];
    end else if (char_idx < 10'(TEXT_CHARS)) begin
      ascii = suffix[8*(TEXT_CHARS-1-int'(char_idx)) +: 8];
    end
  end

  always_ff @(posedge clk) begin
    char_code_q <= 7'(ascii - 8'd32);  // rom starts at space
  end

  // current pixel position inside its cell
  assign x_off     = fetch.x - 10'(TEXT_START_X);
  assign y_off     = fetch.y - 10'(TEXT_START_Y);
  assign glyph_col = 3'((x_off % CELL_W) / UI_SCALE);
  assign glyph_row = 3'((y_off % CELL_W) / UI_SCALE);
  assign text_hit  = (fetch.x >= 10'(TEXT_START_X)) && (fetch.x < 10'(TEXT_END_X)) &&
                     (fetch.y >= 10'(TEXT_START_Y)) && (fetch.y < 10'(TEXT_END_Y));
  assign band_hit  = (fetch.y >= 10'(BAND_START_Y)) && (fetch.y < 10'(BAND_END_Y)) &&
                     (fetch.y < 10'(V_ACTIVE));

  always_ff @(posedge clk) begin
    col_q <= glyph_col;  // meets the rom data
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      text_q <= 1'b0;
      band_q <= 1'b0;
    end else begin
      text_q <= text_hit;
      band_q <= band_hit;
    end
  end

  char_rom u_char_rom (
    .clk       (clk),
    .code      (char_code_q),
    .row       (glyph_row),
    .font_line (font_line)
  );

  assign overlay_pixel = text_q & font_line[3'd7 - col_q];
  assign in_band       = band_q;

endmodule

/* source/video_mixer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Overlay and background mixer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module video_mixer (
  input  logic                clk,
  input  logic                rst_n,
  input  overlay_pkg::fetch_t fetch,
  input  overlay_pkg::rgb_t   background,
  input  logic                overlay_pixel,
  input  logic                in_band,
  output overlay_pkg::video_t video_out
);

  localparam overlay_pkg::rgb_t WHITE = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};
  localparam overlay_pkg::rgb_t BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};

  overlay_pkg::video_t stage_q;  // background and timing, one pixel late
  overlay_pkg::rgb_t   mixed;

  always_comb begin
    mixed = stage_q.rgb;
    if (in_band) mixed = overlay_pixel ? WHITE : BLACK;  // band is opaque
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q   <= '0;
      video_out <= '0;
    end else begin
      stage_q.rgb     <= background;
      stage_q.de      <= fetch.de;
      stage_q.hsync   <= fetch.hsync;
      stage_q.vsync   <= fetch.vsync;
      video_out.rgb   <= mixed;
      video_out.de    <= stage_q.de;
      video_out.hsync <= stage_q.hsync;
      video_out.vsync <= stage_q.vsync;
    end
  end

endmodule

/* source/video_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster timing generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module video_timing #(
  parameter int H_ACTIVE = 360,
  parameter int H_TOTAL  = 400,
  parameter int V_ACTIVE = 320,
  parameter int V_TOTAL  = 330
) (
  input  logic                clk,
  input  logic                rst_n,
  output overlay_pkg::fetch_t fetch
);

  localparam int H_BLANK     = H_TOTAL - H_ACTIVE;
  localparam int V_BLANK     = V_TOTAL - V_ACTIVE;
  localparam int HSYNC_START = H_ACTIVE + H_BLANK / 4;
  localparam int HSYNC_END   = HSYNC_START + H_BLANK / 2;
  localparam int VSYNC_START = V_ACTIVE + V_BLANK / 4;
  localparam int VSYNC_END   = VSYNC_START + V_BLANK / 2;

  logic [9:0] x_next;
  logic [9:0] y_next;

  always_comb begin
    x_next = fetch.x + 10'd1;
    y_next = fetch.y;
    if (fetch.x == 10'(H_TOTAL - 1)) begin  // end of line
      x_next = '0;
      y_next = (fetch.y == 10'(V_TOTAL - 1)) ? '0 : fetch.y + 10'd1;
    end
  end

  // the fetch register doubles as the pixel and line counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch.x     <= '0;
      fetch.y     <= '0;
      fetch.de    <= 1'b1;  // origin is an active pixel
      fetch.hsync <= 1'b0;
      fetch.vsync <= 1'b0;
    end else begin
      fetch.x     <= x_next;
      fetch.y     <= y_next;
      fetch.de    <= (x_next < 10'(H_ACTIVE)) && (y_next < 10'(V_ACTIVE));
      fetch.hsync <= (x_next >= 10'(HSYNC_START)) && (x_next < 10'(HSYNC_END));
      fetch.vsync <= (y_next >= 10'(VSYNC_START)) && (y_next < 10'(VSYNC_END));
    end
  end

endmodule

/* tests/tb_overlay.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Status overlay testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_overlay;

  localparam int H_ACTIVE     = 360;
  localparam int H_TOTAL      = 400;
  localparam int V_ACTIVE     = 320;
  localparam int V_TOTAL      = 330;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // samples 2, band 1, label 1, speeds 8, plus one spare frame
  localparam int MAX_CYCLES   = 13 * FRAME_CYCLES + FRAME_CYCLES / 4;
  localparam int TEXT_X       = 52;  // (360 - 256) / 2
  localparam int TEXT_Y       = 286;
  localparam overlay_pkg::rgb_t WHITE = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};
  localparam overlay_pkg::rgb_t BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};

  logic                clk;
  logic                rst_n;
  logic [2:0]          turbo_speed;
  overlay_pkg::rgb_t   background;
  overlay_pkg::video_t video_out;

  int          cur_x = 0;  // coordinate on fetch
  int          cur_y = 0;
  int          mid_x = 0;
  int          mid_y = 0;
  int          out_x = 0;  // coordinate now on video_out
  int          out_y = 0;
  int          live_edges = 0;
  int          cycles = 0;
  int          test_bad = 0;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  logic [31:0] rng = 32'd73851;

  overlay_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .turbo_speed (turbo_speed),
    .background  (background),
    .video_out   (video_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic overlay_pkg::rgb_t bg_rgb(input int x, input int y);
    return '{r: 8'(x), g: 8'(y), b: 8'h5A};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // top row in the high byte, bit 7 leftmost
  function automatic logic glyph_bit(input logic [7:0] ch, input int row, input int col);
    logic [63:0] g;
    case (ch)
      "T":     g = 64'hFCB4303030307800;
      "0":     g = 64'h7CC6CEDEF6E67C00;
      "1":     g = 64'h30703030303030FC;
      "2":     g = 64'h78CC0C3860CCFC00;
      "4":     g = 64'h1C3C6CCCFE0C1E00;
      "5":     g = 64'hFCC0F80C0CCC7800;
      "x":     g = 64'h0000C66C386CC600;
      "M":     g = 64'hC6EEFEFED6C6C600;
      "a":     g = 64'h0000780C7CCC7600;
      default: g = 64'h0000000000000000;  // space
    endcase
    return g[63 - 8 * row - col];
  endfunction

  function automatic logic [23:0] suffix_of(input int speed);
    case (speed)
      0:       return " 1x";
      1:       return " 2x";
      2:       return " 4x";
      3:       return "50x";
      default: return "Max";
    endcase
  endfunction

  // follows fetch and keeps the coordinate two clocks back
  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("STATUS: FAIL");
      $finish;
    end else begin
      out_x = mid_x;
      out_y = mid_y;
      mid_x = cur_x;
      mid_y = cur_y;
      if (!rst_n) begin
        cur_x      = 0;
        cur_y      = 0;
        live_edges = 0;
      end else begin
        live_edges++;
        cur_x = (cur_x == H_TOTAL - 1) ? 0 : cur_x + 1;
        if (cur_x == 0) cur_y = (cur_y == V_TOTAL - 1) ? 0 : cur_y + 1;
      end
      background <= bg_rgb(cur_x, cur_y);
    end
  end

  task automatic check_video(input overlay_pkg::rgb_t exp_rgb);
    logic exp_de;
    exp_de = (out_x < H_ACTIVE) && (out_y < V_ACTIVE);
    assert (video_out.rgb == exp_rgb) else begin
      $display("[ERROR] %0t video_out.rgb at (%0d,%0d) expected %h got %h",
               $time, out_x, out_y, exp_rgb, video_out.rgb);
      test_bad++;
    end
    assert (video_out.de == exp_de) else begin
      $display("[ERROR] %0t video_out.de at (%0d,%0d) expected %b got %b",
               $time, out_x, out_y, exp_de, video_out.de);
      test_bad++;
    end
    // syncs only pulse in the blanking interval
    assert (!(out_x < H_ACTIVE && video_out.hsync)) else begin
      $display("[ERROR] %0t video_out.hsync at (%0d,%0d) expected 0 got %b",
               $time, out_x, out_y, video_out.hsync);
      test_bad++;
    end
    assert (!(out_y < V_ACTIVE && video_out.vsync)) else begin
      $display("[ERROR] %0t video_out.vsync at (%0d,%0d) expected 0 got %b",
               $time, out_x, out_y, video_out.vsync);
      test_bad++;
    end
  endtask

  task automatic wait_for(input int x, input int y);
    do begin
      @(negedge clk);
    end while (!(live_edges >= 2 && out_x == x && out_y == y));
  endtask

  task automatic finish_test(input string name);
    if (test_bad == 0) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d mismatches", name, test_bad);
    end
    errors += test_bad;
    test_bad = 0;
  endtask

  task automatic reset_state();
    int i;
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      if (i == 7) rst_n <= 1'b1;
      @(negedge clk);
      if (i < 9) begin  // pipeline still empty
        assert (video_out == '0) else begin
          $display("[ERROR] %0t video_out expected %h got %h", $time, 27'd0, video_out);
          test_bad++;
        end
      end
    end
    check_video(bg_rgb(0, 0));  // origin, de high
    finish_test("reset state");
  endtask

  task automatic background_passthrough();
    int n;
    int pos;
    pos = out_y * H_TOTAL + out_x;
    for (n = 0; n < 200; n++) begin
      rng = xorshift(rng);
      pos = (pos + 1 + int'(rng % 32'd1000)) % FRAME_CYCLES;
      if (pos / H_TOTAL >= 276 && pos / H_TOTAL <= 311) begin
        pos = (pos + 36 * H_TOTAL) % FRAME_CYCLES;  // skip the band
      end
      wait_for(pos % H_TOTAL, pos / H_TOTAL);
      check_video(bg_rgb(pos % H_TOTAL, pos / H_TOTAL));
    end
    finish_test("background passthrough");
  endtask

  task automatic band_blanking();
    logic done;
    wait_for(0, 276);
    done = 1'b0;
    while (!done) begin
      if (out_y < TEXT_Y || out_y >= TEXT_Y + 16 || out_x < TEXT_X || out_x >= TEXT_X + 256) begin
        check_video(BLACK);
      end
      done = (out_x == H_TOTAL - 1) && (out_y == 311);
      if (!done) @(negedge clk);
    end
    finish_test("band blanking");
  endtask

  // chars holds up to three characters, first in the top byte
  task automatic check_text(input int first, input int count, input logic [23:0] chars);
    int line;
    int px;
    logic [7:0] ch;
    for (line = 0; line < 16; line++) begin
      wait_for(TEXT_X + 16 * first, TEXT_Y + line);
      for (px = 0; px < 16 * count; px++) begin
        ch = chars[23 - 8 * (px / 16) -: 8];
        check_video(glyph_bit(ch, line / 2, (px % 16) / 2) ? WHITE : BLACK);
        if (px < 16 * count - 1) @(negedge clk);
      end
    end
  endtask

  task automatic label_glyph();
    check_text(0, 1, {"T", 16'h0000});
    finish_test("label glyph");
  endtask

  task automatic speed_suffix();
    int s;
    for (s = 0; s < 8; s++) begin
      @(posedge clk);
      turbo_speed <= 3'(s);  // text of this frame already done
      check_text(13, 3, suffix_of(s));
    end
    finish_test("speed suffix");
  endtask

  initial begin
    rst_n       = 1'b0;
    turbo_speed = 3'd0;
    background  = '0;
    reset_state();
    background_passthrough();
    band_blanking();
    label_glyph();
    speed_suffix();
    $display("tests passed: %0d, failed: %0d, mismatches: %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
